// ==== common/eth_rx_pkg.sv ====
// Shared types for the 64-bit Ethernet receive path.
// Byte lane 0 is the first byte on the wire. The widths are fixed to 8 lanes.
`default_nettype none

package eth_rx_pkg;

    // header length on the wire, destination and source MAC plus Ethertype
    localparam int ETH_HDR_BYTES = 14;

    // one stream beat, used on both the input and the payload side
    typedef struct packed {
        logic [63:0] data;
        // one bit per byte lane
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } axis_word_t;

    // decoded header, the first wire byte is the MSB of each field
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

    // frame controller states
    // header word 0 is taken in idle, word 1 in ST_HDR
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_HDR,
        ST_PAYLOAD,
        // the saved two lanes still have to go out
        ST_TAIL
    } rx_state_t;

endpackage

`default_nettype wire

// ==== eth_rx/eth_rx_ctrl.sv ====
// Frame FSM of the receive path. in_ready is registered and so lags the
// decision by one cycle. A new frame is held off while a header is pending.
// Frames that end inside the header give a one-cycle error pulse.
`timescale 1ns/10ps
`default_nettype none

module eth_rx_ctrl import eth_rx_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  in_valid,
    input  wire  in_last,
    input  wire  short_last,
    input  wire  ready_early,
    input  wire  mid_ready,
    input  wire  hdr_ready,
    output logic in_ready,
    output logic hdr_valid,
    output logic store_hdr0,
    output logic store_hdr1,
    output logic save_load,
    output logic save_flush,
    output logic tail_sel,
    output logic busy,
    output logic err_hdr_early
);

    rx_state_t state;
    rx_state_t state_next;
    logic      ready_next;
    logic      hdr_valid_next;
    logic      err_next;
    logic      in_fire;

    assign in_fire = in_valid & in_ready;

    always_comb begin
        state_next     = state;
        ready_next     = 1'b0;
        store_hdr0     = 1'b0;
        store_hdr1     = 1'b0;
        save_load      = 1'b0;
        save_flush     = 1'b0;
        tail_sel       = 1'b0;
        err_next       = 1'b0;
        // header stays up until it is taken
        hdr_valid_next = hdr_valid & ~hdr_ready;

        case (state)
            ST_IDLE: begin
                save_flush = 1'b1;
                ready_next = ~hdr_valid_next;
                if (in_fire) begin
                    if (in_last) begin
                        err_next = 1'b1;
                    end else begin
                        store_hdr0 = 1'b1;
                        ready_next = 1'b1;
                        state_next = ST_HDR;
                    end
                end
            end
            ST_HDR: begin
                ready_next = 1'b1;
                if (in_fire) begin
                    save_load = 1'b1;
                    if (in_last && !short_last) begin
                        // frame ended before the Ethertype was complete
                        err_next   = 1'b1;
                        save_flush = 1'b1;
                        ready_next = ~hdr_valid_next;
                        state_next = ST_IDLE;
                    end else begin
                        store_hdr1     = 1'b1;
                        hdr_valid_next = 1'b1;
                        if (in_last) begin
                            ready_next = 1'b0;
                            state_next = ST_TAIL;
                        end else begin
                            ready_next = ready_early;
                            state_next = ST_PAYLOAD;
                        end
                    end
                end
            end
            ST_PAYLOAD: begin
                ready_next = ready_early;
                if (in_fire) begin
                    save_load = 1'b1;
                    if (in_last && short_last) begin
                        ready_next = 1'b0;
                        state_next = ST_TAIL;
                    end else if (in_last) begin
                        save_flush = 1'b1;
                        ready_next = ~hdr_valid_next;
                        state_next = ST_IDLE;
                    end
                end
            end
            ST_TAIL: begin
                tail_sel = 1'b1;
                if (mid_ready) begin
                    save_flush = 1'b1;
                    ready_next = ~hdr_valid_next;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state         <= ST_IDLE;
            in_ready      <= 1'b0;
            hdr_valid     <= 1'b0;
            busy          <= 1'b0;
            err_hdr_early <= 1'b0;
        end else begin
            state         <= state_next;
            in_ready      <= ready_next;
            hdr_valid     <= hdr_valid_next;
            busy          <= (state_next != ST_IDLE);
            err_hdr_early <= err_next;
        end
    end

endmodule

`default_nettype wire

// ==== eth_rx/eth_hdr_capture.sv ====
// Header field registers. Word 0 holds bytes 0 to 7 and word 1 bytes 8 to 13.
// Wire lane 0 lands in the most significant byte of each field.
`timescale 1ns/10ps
`default_nettype none

module eth_hdr_capture import eth_rx_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire  [63:0] data,
    input  wire         store_hdr0,
    input  wire         store_hdr1,
    output eth_hdr_t    hdr
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr <= '0;
        end else begin
            if (store_hdr0) begin
                // lanes 0..5 are the destination MAC
                for (int i = 0; i < 6; i++) begin
                    hdr.dest_mac[47-8*i -: 8] <= data[8*i +: 8];
                end
                // lanes 6 and 7 start the source MAC
                hdr.src_mac[47:40] <= data[55:48];
                hdr.src_mac[39:32] <= data[63:56];
            end
            if (store_hdr1) begin
                for (int i = 0; i < 4; i++) begin
                    hdr.src_mac[31-8*i -: 8] <= data[8*i +: 8];
                end
                // Ethertype in lanes 4 and 5, big endian on the wire
                hdr.eth_type[15:8] <= data[39:32];
                hdr.eth_type[7:0]  <= data[47:40];
            end
        end
    end

endmodule

`default_nettype wire

// ==== eth_rx/eth_payload_align.sv ====
// Shifts the payload down by the six header lanes of the second word.
// Each output beat is the saved lanes 6 and 7 joined with lanes 0 to 5 of
// the current beat. A final beat with lanes 6 or 7 set needs a tail beat.
`timescale 1ns/10ps
`default_nettype none

module eth_payload_align import eth_rx_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire  axis_word_t in_word,
    input  wire         in_fire,
    input  wire         save_load,
    input  wire         save_flush,
    input  wire         tail_sel,
    output logic        short_last,
    output axis_word_t  mid_word,
    output logic        mid_valid
);

    // header lanes in the second word, 6 for a 14-byte header
    localparam int HDR_TAIL = ETH_HDR_BYTES - 8;

    axis_word_t save_word;
    logic       save_valid;
    logic       tail_bytes;

    assign tail_bytes = |in_word.keep[7:HDR_TAIL];
    assign short_last = in_word.last & tail_bytes;

    always_comb begin
        if (tail_sel) begin
            // only the two saved lanes are left
            mid_word.data = {{(8*HDR_TAIL){1'b0}}, save_word.data[63:8*HDR_TAIL]};
            mid_word.keep = {{HDR_TAIL{1'b0}}, save_word.keep[7:HDR_TAIL]};
            mid_word.last = 1'b1;
            mid_word.user = save_word.user;
            mid_valid     = 1'b1;
        end else begin
            mid_word.data = {in_word.data[8*HDR_TAIL-1:0], save_word.data[63:8*HDR_TAIL]};
            mid_word.keep = {in_word.keep[HDR_TAIL-1:0], save_word.keep[7:HDR_TAIL]};
            mid_word.last = in_word.last & ~tail_bytes;
            mid_word.user = in_word.user & in_word.last & ~tail_bytes;
            // nothing comes out until a beat sits in the save register
            mid_valid     = in_fire & save_valid;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            save_valid <= 1'b0;
        end else if (save_flush) begin
            save_valid <= 1'b0;
        end else if (save_load) begin
            save_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (save_load) begin
            save_word <= in_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/axis_out_reg.sv ====
// Two-entry skid register on the payload stream.
// mid_ready is ready_early delayed by a cycle, so the upstream side must
// only present beats on cycles where mid_ready is high.
`timescale 1ns/10ps
`default_nettype none

module axis_out_reg import eth_rx_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire  axis_word_t mid_word,
    input  wire         mid_valid,
    output logic        mid_ready,
    output logic        ready_early,
    output axis_word_t  out_word,
    output logic        out_valid,
    input  wire         out_ready
);

    axis_word_t temp_word;
    logic       temp_valid;
    logic       load_out;
    logic       load_temp;
    logic       drain_temp;

    // space next cycle: output moves, both empty, or temp free and no beat arrives
    assign ready_early = out_ready | (~temp_valid & ~out_valid) | (~temp_valid & ~mid_valid);

    assign load_out   = mid_ready & (out_ready | ~out_valid);
    assign load_temp  = mid_ready & ~out_ready & out_valid;
    assign drain_temp = ~mid_ready & out_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mid_ready  <= 1'b0;
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
        end else begin
            mid_ready <= ready_early;
            if (load_out) begin
                out_valid <= mid_valid;
            end else if (load_temp) begin
                temp_valid <= mid_valid;
            end else if (drain_temp) begin
                // temp goes out first when the stall clears
                out_valid  <= temp_valid;
                temp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            out_word <= mid_word;
        end else if (load_temp) begin
            temp_word <= mid_word;
        end else if (drain_temp) begin
            out_word <= temp_word;
        end
    end

endmodule

`default_nettype wire

// ==== hw/eth_rx_top.sv ====
// Ethernet receive top, 64-bit stream in, header fields and payload out.
// No FCS check, no VLAN handling, no length limits.
`timescale 1ns/10ps
`default_nettype none

module eth_rx_top import eth_rx_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire  axis_word_t in_word,
    input  wire         in_valid,
    output logic        in_ready,
    output eth_hdr_t    hdr,
    output logic        hdr_valid,
    input  wire         hdr_ready,
    output axis_word_t  out_word,
    output logic        out_valid,
    input  wire         out_ready,
    output logic        busy,
    output logic        err_hdr_early
);

    logic       in_fire;
    logic       store_hdr0;
    logic       store_hdr1;
    logic       save_load;
    logic       save_flush;
    logic       tail_sel;
    logic       short_last;
    logic       ready_early;
    logic       mid_ready;
    logic       mid_valid;
    axis_word_t mid_word;

    assign in_fire = in_valid & in_ready;

    eth_rx_ctrl ctrl_i (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_last(in_word.last), .short_last(short_last),
        .ready_early(ready_early), .mid_ready(mid_ready), .hdr_ready(hdr_ready),
        .in_ready(in_ready), .hdr_valid(hdr_valid),
        .store_hdr0(store_hdr0), .store_hdr1(store_hdr1),
        .save_load(save_load), .save_flush(save_flush), .tail_sel(tail_sel),
        .busy(busy), .err_hdr_early(err_hdr_early)
    );

    eth_hdr_capture hdr_i (
        .clk(clk), .rst(rst), .data(in_word.data),
        .store_hdr0(store_hdr0), .store_hdr1(store_hdr1), .hdr(hdr)
    );

    eth_payload_align align_i (
        .clk(clk), .rst(rst), .in_word(in_word), .in_fire(in_fire),
        .save_load(save_load), .save_flush(save_flush), .tail_sel(tail_sel),
        .short_last(short_last), .mid_word(mid_word), .mid_valid(mid_valid)
    );

    axis_out_reg out_i (
        .clk(clk), .rst(rst), .mid_word(mid_word), .mid_valid(mid_valid),
        .mid_ready(mid_ready), .ready_early(ready_early),
        .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
// Clock and reset source for the testbench.
// 20 ns period, reset held for 8 cycles and released on a falling edge.
`timescale 1ns/10ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/eth_rx_tb.sv ====
// Testbench for eth_rx_top. Frames come from random bytes, the expected
// header and payload beats are queued per frame and checked at each transfer.
// Unused input lanes are driven as zero. Payload data is compared on kept lanes only.
`timescale 1ns/10ps
`default_nettype none

module eth_rx_tb import eth_rx_pkg::*; ();

    logic        clk;
    logic        rst;
    axis_word_t  in_word;
    logic        in_valid;
    logic        in_ready;
    eth_hdr_t    hdr;
    logic        hdr_valid;
    logic        hdr_ready;
    axis_word_t  out_word;
    logic        out_valid;
    logic        out_ready;
    logic        busy;
    logic        err_hdr_early;

    // expected values with queue heads refreshed on the falling edge
    eth_hdr_t    hdr_q[$];
    axis_word_t  out_q[$];
    eth_hdr_t    hdr_head;
    axis_word_t  out_head;
    logic [63:0] out_mask;
    logic        hdr_avail;
    logic        out_avail;

    // stimulus modes and per-word flags
    logic        mid_frame;
    logic        err_word;
    logic        rand_out;
    logic        rand_hdr;
    logic        hold_hdr;
    logic        in_gaps;

    int error_count = 0;
    int test_errors = 0;
    int err_expected = 0;
    int err_seen = 0;
    int frame_count = 0;
    int cycle_count = 0;
    int cycle_limit = 200;

    int len_list[12] = '{15, 16, 17, 20, 21, 22, 23, 24, 29, 30, 31, 44};

    tb_clkgen clkgen_i (.clk(clk), .rst(rst));

    eth_rx_top dut_i (
        .clk(clk), .rst(rst),
        .in_word(in_word), .in_valid(in_valid), .in_ready(in_ready),
        .hdr(hdr), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .out_word(out_word), .out_valid(out_valid), .out_ready(out_ready),
        .busy(busy), .err_hdr_early(err_hdr_early)
    );

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] act);
        $display("ERROR %0s expected %0h got %0h", name, exp, act);
        error_count++;
    endtask

    task automatic report_failure(input string msg);
        $display("at %0d ns: %0s", $time, msg);
        error_count++;
    endtask

    function automatic logic [63:0] lane_mask(input logic [7:0] keep);
        logic [63:0] m;
        for (int i = 0; i < 8; i++) begin
            m[8*i +: 8] = {8{keep[i]}};
        end
        return m;
    endfunction

    // input words plus output beats of one frame
    function automatic int frame_beats(input int flen);
        int beats;
        beats = (flen + 7) / 8;
        if (flen > ETH_HDR_BYTES) begin
            beats += (flen - ETH_HDR_BYTES + 7) / 8;
        end
        return beats;
    endfunction

    always @(negedge clk) begin
        out_ready <= rand_out ? ($urandom % 4 != 0) : 1'b1;
        hdr_ready <= hold_hdr ? 1'b0 : (rand_hdr ? 1'($urandom) : 1'b1);
    end

    always @(negedge clk) begin
        hdr_avail = (hdr_q.size() != 0);
        out_avail = (out_q.size() != 0);
        if (hdr_avail) begin
            hdr_head = hdr_q[0];
        end
        if (out_avail) begin
            out_head = out_q[0];
            out_mask = lane_mask(out_q[0].keep);
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (hdr_valid && hdr_ready && hdr_q.size() != 0) begin
                void'(hdr_q.pop_front());
            end
            if (out_valid && out_ready && out_q.size() != 0) begin
                void'(out_q.pop_front());
            end
            if (err_hdr_early) begin
                err_seen++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT stopped making progress", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    a_hdr_expected: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && hdr_ready |-> hdr_avail)
        else report_failure("header transferred although none was expected");
    a_hdr_value: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && hdr_ready && hdr_avail |-> hdr == hdr_head)
        else report_mismatch("hdr", $sampled(hdr_head), $sampled(hdr));
    a_out_expected: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready |-> out_avail)
        else report_failure("payload beat transferred although none was expected");
    a_out_data: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && out_avail |-> (out_word.data & out_mask) == out_head.data)
        else report_mismatch("out_word.data", $sampled(out_head.data),
                             $sampled(out_word.data) & $sampled(out_mask));
    a_out_keep: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && out_avail |-> out_word.keep == out_head.keep)
        else report_mismatch("out_word.keep", $sampled(out_head.keep), $sampled(out_word.keep));
    a_out_last: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && out_avail |-> out_word.last == out_head.last)
        else report_mismatch("out_word.last", $sampled(out_head.last), $sampled(out_word.last));
    a_out_user: assert property (@(posedge clk) disable iff (rst)
        out_valid && out_ready && out_avail |-> out_word.user == out_head.user)
        else report_mismatch("out_word.user", $sampled(out_head.user), $sampled(out_word.user));
    a_out_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_word))
        else report_failure("out_valid dropped or out_word changed before the transfer");
    a_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> hdr_valid && $stable(hdr))
        else report_failure("hdr_valid dropped or hdr changed before the transfer");
    a_hdr_pending: assert property (@(posedge clk) disable iff (rst)
        !busy && hdr_valid |-> !in_ready)
        else report_failure("in_ready high in idle while a header is pending");
    a_busy_mid: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && mid_frame |-> busy)
        else report_failure("busy low while a frame was being received");
    a_busy_start: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && !in_word.last |=> busy)
        else report_failure("busy did not rise after an accepted word");
    a_err_timing: assert property (@(posedge clk) disable iff (rst)
        in_valid && in_ready && err_word |=> err_hdr_early)
        else report_failure("no err_hdr_early pulse after a too short frame");
    a_err_pulse: assert property (@(posedge clk) disable iff (rst)
        err_hdr_early |=> !err_hdr_early)
        else report_failure("err_hdr_early longer than one cycle");

    // runs from a falling edge to the falling edge after the transfer
    task automatic drive_word(input axis_word_t w);
        logic taken;
        taken    = 1'b0;
        in_word  = w;
        in_valid = 1'b1;
        while (!taken) begin
            taken = in_ready;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic send_frame(input int flen, input logic fin_user, input logic other_user);
        logic [7:0] fb [0:127];
        eth_hdr_t   h;
        axis_word_t w;
        int         nwords;
        cycle_limit += 4 * frame_beats(flen);
        for (int i = 0; i < flen; i++) begin
            fb[i] = 8'($urandom);
        end
        h.dest_mac = {fb[0], fb[1], fb[2], fb[3], fb[4], fb[5]};
        h.src_mac  = {fb[6], fb[7], fb[8], fb[9], fb[10], fb[11]};
        h.eth_type = {fb[12], fb[13]};
        if (flen > ETH_HDR_BYTES) begin
            hdr_q.push_back(h);
            // beat k holds frame bytes 14+8k to 21+8k
            for (int k = 0; ETH_HDR_BYTES + 8*k < flen; k++) begin
                w = '0;
                for (int j = 0; j < 8; j++) begin
                    if (ETH_HDR_BYTES + 8*k + j < flen) begin
                        w.data[8*j +: 8] = fb[ETH_HDR_BYTES + 8*k + j];
                        w.keep[j]        = 1'b1;
                    end
                end
                w.last = (ETH_HDR_BYTES + 8*k + 8 >= flen);
                w.user = w.last & fin_user;
                out_q.push_back(w);
            end
        end else begin
            err_expected++;
        end
        nwords = (flen + 7) / 8;
        for (int n = 0; n < nwords; n++) begin
            w = '0;
            for (int j = 0; j < 8; j++) begin
                if (8*n + j < flen) begin
                    w.data[8*j +: 8] = fb[8*n + j];
                    w.keep[j]        = 1'b1;
                end
            end
            w.last = (n == nwords - 1);
            w.user = w.last ? fin_user : other_user;
            if (in_gaps) begin
                repeat ($urandom % 3) @(negedge clk);
            end
            mid_frame = (n != 0);
            err_word  = w.last && (flen <= ETH_HDR_BYTES);
            drive_word(w);
        end
        mid_frame = 1'b0;
        err_word  = 1'b0;
        frame_count++;
    endtask

    task automatic finish_test(input string name);
        while (hdr_q.size() != 0 || out_q.size() != 0 || busy || out_valid || hdr_valid) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        assert (err_seen == err_expected)
            else report_mismatch("err_hdr_early pulses", err_expected, err_seen);
        $display("test %0s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    initial begin
        void'($urandom(18));
        in_word    = '0;
        in_valid   = 1'b0;
        out_ready  = 1'b1;
        hdr_ready  = 1'b1;
        mid_frame  = 1'b0;
        err_word   = 1'b0;
        rand_out   = 1'b0;
        rand_hdr   = 1'b0;
        hold_hdr   = 1'b0;
        in_gaps    = 1'b0;

        @(negedge rst);
        assert (!in_ready && !hdr_valid && !out_valid && !busy && !err_hdr_early)
            else report_failure("outputs not low after reset");
        @(negedge clk);
        assert (in_ready) else report_failure("in_ready did not rise after reset");
        finish_test("reset");

        // payload of 1, 2, 3, 6, 7, 8, 9, 10, 15, 16, 17 and 30 bytes
        foreach (len_list[i]) begin
            send_frame(len_list[i], 1'($urandom), 1'($urandom));
        end
        finish_test("lengths");

        send_frame(23, 1'b1, 1'b0);
        send_frame(22, 1'b1, 1'b0);
        send_frame(16, 1'b0, 1'b1);
        send_frame(30, 1'b1, 1'b1);
        finish_test("user_bit");

        send_frame(8, 1'b0, 1'b0);
        send_frame(14, 1'b1, 1'b0);
        send_frame(34, 1'b1, 1'b0);
        finish_test("short_frames");

        rand_out = 1'b1;
        rand_hdr = 1'b1;
        in_gaps  = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_frame(15 + int'($urandom % 64), 1'($urandom), 1'($urandom));
        end
        finish_test("backpressure");
        rand_out = 1'b0;
        rand_hdr = 1'b0;
        in_gaps  = 1'b0;

        // next frame waits in idle while the header is held back
        hold_hdr = 1'b1;
        send_frame(24, 1'b0, 1'b0);
        fork
            send_frame(17, 1'b1, 1'b0);
            begin
                repeat (30) @(negedge clk);
                assert (hdr_valid && !busy && !in_ready)
                    else report_failure("next frame started while a header was pending");
                hold_hdr = 1'b0;
            end
        join
        finish_test("header_hold");

        $display("6 tests, %0d frames, %0d errors", frame_count, error_count);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
common/eth_rx_pkg.sv
eth_rx/eth_rx_ctrl.sv
eth_rx/eth_hdr_capture.sv
eth_rx/eth_payload_align.sv
hw/axis_out_reg.sv
hw/eth_rx_top.sv
verif/tb_clkgen.sv
verif/eth_rx_tb.sv

// ==== Bender.yml ====
package:
  name: eth_rx

sources:
  - common/eth_rx_pkg.sv
  - eth_rx/eth_rx_ctrl.sv
  - eth_rx/eth_hdr_capture.sv
  - eth_rx/eth_payload_align.sv
  - hw/axis_out_reg.sv
  - hw/eth_rx_top.sv
  - target: test
    files:
      - verif/tb_clkgen.sv
      - verif/eth_rx_tb.sv
